// File: source/sdramGeomPkg.sv
`default_nettype none

package sdramGeomPkg;

	// Host side word address and data
	localparam int AddrWidth = 22;
	localparam int DataWidth = 16;

	// Address fields, bank on top, column at the bottom
	localparam int BankWidth = 2;
	localparam int RowWidth  = 12;
	localparam int ColWidth  = 8;

	localparam int RowLsb  = ColWidth;
	localparam int BankLsb = ColWidth + RowWidth; // 20

	// One mask bit per byte lane
	localparam int MaskWidth = DataWidth / 8;

endpackage

`default_nettype wire

// File: source/sdramCmdPkg.sv
`default_nettype none

package sdramCmdPkg;

	localparam int SdramAddrWidth = 12;

	// {csN, rasN, casN, weN}
	typedef enum logic [3:0] {
		CmdModeSet   = 4'b0000,
		CmdRefresh   = 4'b0001,
		CmdPrecharge = 4'b0010,
		CmdActive    = 4'b0011,
		CmdWrite     = 4'b0100,
		CmdRead      = 4'b0101,
		CmdNop       = 4'b0111
	} sdramCmd;

	// CAS latency 2, sequential, burst length 1
	localparam logic [SdramAddrWidth-1:0] ModeRegValue = 12'h020;

	// A10 selects auto precharge on READ/WRITE and all banks on PRECHARGE
	localparam int AutoPrechargeBit = 10;

endpackage

`default_nettype wire

// File: source/sdramRefreshSched.sv
`timescale 1ns/100ps
`default_nettype none

module sdramRefreshSched #(
	parameter int PowerUpCycles = 10000,
	parameter int RefreshCycles = 390
) (
	input  logic sys_clk,
	input  logic rstn,
	input  logic refreshIssued,
	output logic powerUpDone,
	output logic refreshDue
);

	localparam int PowerUpWidth  = $clog2(PowerUpCycles + 1);
	localparam int IntervalWidth = $clog2(RefreshCycles + 1);

	logic [PowerUpWidth-1:0]  powerUpCnt;
	logic [IntervalWidth-1:0] intervalCnt;

	// Power-up wait, stops at the limit so the done level holds
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			powerUpCnt <= '0;
		end else if (!powerUpDone) begin
			powerUpCnt <= powerUpCnt + 1'b1;
		end
	end

	assign powerUpDone = (powerUpCnt == PowerUpWidth'(PowerUpCycles));

	// Refresh interval
	// Starts once the power-up wait is over
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			intervalCnt <= '0;
		end else if (refreshIssued) begin
			intervalCnt <= '0; // Restart from the refresh just issued
		end else if (powerUpDone && !refreshDue) begin
			intervalCnt <= intervalCnt + 1'b1;
		end
	end

	// Saturated count keeps the request up until it is served
	assign refreshDue = (intervalCnt == IntervalWidth'(RefreshCycles));

endmodule

`default_nettype wire

// File: source/sdramHostPort.sv
`timescale 1ns/100ps
`default_nettype none

module sdramHostPort
	import sdramGeomPkg::*;
(
	input  logic                 sys_clk,
	input  logic                 rstn,

	// Host request
	input  logic [AddrWidth-1:0] hostAddr,
	input  logic [MaskWidth-1:0] hostByteEn,
	input  logic                 hostWrite,
	input  logic [DataWidth-1:0] hostWrData,
	output logic [DataWidth-1:0] hostRdData,

	// From the sequencer
	input  logic                 accept,
	input  logic                 driveData,

	// Latched request to the sequencer
	output logic [BankWidth-1:0] bank,
	output logic [RowWidth-1:0]  row,
	output logic [ColWidth-1:0]  col,
	output logic                 reqWrite,

	// SDRAM data pins
	output logic [MaskWidth-1:0] dqm,
	inout  wire  [DataWidth-1:0] dq
);

	logic [DataWidth-1:0] wrData;

	// Direction and lane mask
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			reqWrite <= 1'b0;
			dqm      <= '1; // All lanes masked until a request arrives
		end else if (accept) begin
			reqWrite <= hostWrite;
			dqm      <= ~hostByteEn;
		end
	end

	// Address fields and write payload
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			bank   <= hostAddr[BankLsb +: BankWidth];
			row    <= hostAddr[RowLsb +: RowWidth];
			col    <= hostAddr[ColWidth-1:0];
			wrData <= hostWrData;
		end
	end

	// Drive only in the WRITE command cycle
	assign dq = driveData ? wrData : {DataWidth{1'bz}};

	// Read data is taken straight off the pins
	assign hostRdData = dq;

endmodule

`default_nettype wire

// File: source/sdramCmdSeq.sv
`timescale 1ns/100ps
`default_nettype none

module sdramCmdSeq
	import sdramGeomPkg::*, sdramCmdPkg::*;
#(
	parameter int InitRefreshes = 8
) (
	input  logic                      sys_clk,
	input  logic                      rstn,

	// Refresh scheduler
	input  logic                      powerUpDone,
	input  logic                      refreshDue,
	output logic                      refreshIssued,

	// Host strobes and wait
	input  logic                      hostRead,
	input  logic                      hostWrite,
	output logic                      hostWait,

	// Host port
	input  logic [BankWidth-1:0]      bank,
	input  logic [RowWidth-1:0]       row,
	input  logic [ColWidth-1:0]       col,
	input  logic                      reqWrite,
	output logic                      accept,
	output logic                      driveData,

	// SDRAM command and address pins
	output logic                      csN,
	output logic                      rasN,
	output logic                      casN,
	output logic                      weN,
	output logic [BankWidth-1:0]      ba,
	output logic [SdramAddrWidth-1:0] addr
);

	localparam int RefCntWidth = $clog2(InitRefreshes + 1);

	typedef enum logic [4:0] {
		InitWait, InitPall, InitDelay1,
		InitRef, InitDelay2, InitDelay3, InitDelay4,
		InitMode,
		Idle,
		Act,
		WrDelay, WrCmd, WrDone,
		RdDelay1, RdCmd, RdDelay2, RdDone,
		RefCmd, RefDelay
	} seqState;

	seqState state;
	seqState stateNext;

	logic [RefCntWidth-1:0] initRefCnt;
	logic                   lastInitRef;
	sdramCmd                cmd;

	// Counts the init refreshes already completed
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			initRefCnt <= '0;
		end else if (state == InitDelay4) begin
			initRefCnt <= initRefCnt + 1'b1;
		end
	end

	assign lastInitRef = (initRefCnt == RefCntWidth'(InitRefreshes - 1));

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state <= InitWait;
		end else begin
			state <= stateNext;
		end
	end

	// One access at a time, refresh first
	assign accept = (state == Idle) && !refreshDue && (hostRead ^ hostWrite);

	always_comb begin
		stateNext = state;
		case (state)
			InitWait:   if (powerUpDone) stateNext = InitPall;
			InitPall:   stateNext = InitDelay1;
			InitDelay1: stateNext = InitRef;
			InitRef:    stateNext = InitDelay2;
			InitDelay2: stateNext = InitDelay3;
			InitDelay3: stateNext = InitDelay4;
			InitDelay4: stateNext = lastInitRef ? InitMode : InitRef;
			InitMode:   stateNext = Idle;
			Idle: begin
				if (refreshDue) begin
					stateNext = RefCmd;
				end else if (accept) begin
					stateNext = Act;
				end
			end
			Act:        stateNext = reqWrite ? WrDelay : RdDelay1; // Direction latched by now
			WrDelay:    stateNext = WrCmd;
			WrCmd:      stateNext = WrDone;
			WrDone:     stateNext = Idle;
			RdDelay1:   stateNext = RdCmd;
			RdCmd:      stateNext = RdDelay2;
			RdDelay2:   stateNext = RdDone;
			RdDone:     stateNext = Idle;
			RefCmd:     stateNext = RefDelay;
			RefDelay:   stateNext = Idle;
			default:    stateNext = Idle;
		endcase
	end

	// Command, bank and address per state
	always_comb begin
		cmd  = CmdNop;
		ba   = '0;
		addr = '0;
		case (state)
			InitPall: begin
				cmd                    = CmdPrecharge;
				addr[AutoPrechargeBit] = 1'b1; // All banks
			end
			InitRef, RefCmd: cmd = CmdRefresh;
			InitMode: begin
				cmd  = CmdModeSet;
				addr = ModeRegValue;
			end
			Act: begin
				cmd                 = CmdActive;
				ba                  = bank;
				addr[RowWidth-1:0]  = row;
			end
			WrCmd, RdCmd: begin
				cmd                    = (state == WrCmd) ? CmdWrite : CmdRead;
				ba                     = bank;
				addr[ColWidth-1:0]     = col;
				addr[AutoPrechargeBit] = 1'b1; // Close the row after the access
			end
			default: cmd = CmdNop;
		endcase
	end

	assign {csN, rasN, casN, weN} = cmd;

	assign driveData     = (state == WrCmd);
	assign refreshIssued = (state == RefCmd);

	// Low for the last cycle of an access only, read data is on dq then
	assign hostWait = !((state == WrDone) || (state == RdDone));

endmodule

`default_nettype wire

// File: source/sdramCtrlTop.sv
`timescale 1ns/100ps
`default_nettype none

module sdramCtrlTop
	import sdramGeomPkg::*, sdramCmdPkg::*;
#(
	parameter int PowerUpCycles = 10000,
	parameter int RefreshCycles = 390,
	parameter int InitRefreshes = 8
) (
	input  logic                      sys_clk,
	input  logic                      rstn,

	// Host bus
	input  logic [AddrWidth-1:0]      hostAddr,
	input  logic [MaskWidth-1:0]      hostByteEn,
	input  logic                      hostWrite,
	input  logic                      hostRead,
	input  logic [DataWidth-1:0]      hostWrData,
	output logic [DataWidth-1:0]      hostRdData,
	output logic                      hostWait,

	// SDRAM pins
	output logic                      csN,
	output logic                      rasN,
	output logic                      casN,
	output logic                      weN,
	output logic [BankWidth-1:0]      ba,
	output logic [SdramAddrWidth-1:0] addr,
	output logic [MaskWidth-1:0]      dqm,
	inout  wire  [DataWidth-1:0]      dq
);

	logic                 powerUpDone;
	logic                 refreshDue;
	logic                 refreshIssued;
	logic                 accept;
	logic                 driveData;
	logic [BankWidth-1:0] bank;
	logic [RowWidth-1:0]  row;
	logic [ColWidth-1:0]  col;
	logic                 reqWrite;

	sdramRefreshSched #(
		.PowerUpCycles (PowerUpCycles),
		.RefreshCycles (RefreshCycles)
	) sdramRefreshSched_inst (
		.sys_clk       (sys_clk),
		.rstn          (rstn),
		.refreshIssued (refreshIssued),
		.powerUpDone   (powerUpDone),
		.refreshDue    (refreshDue)
	);

	sdramHostPort sdramHostPort_inst (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.hostAddr   (hostAddr),
		.hostByteEn (hostByteEn),
		.hostWrite  (hostWrite),
		.hostWrData (hostWrData),
		.hostRdData (hostRdData),
		.accept     (accept),
		.driveData  (driveData),
		.bank       (bank),
		.row        (row),
		.col        (col),
		.reqWrite   (reqWrite),
		.dqm        (dqm),
		.dq         (dq)
	);

	sdramCmdSeq #(
		.InitRefreshes (InitRefreshes)
	) sdramCmdSeq_inst (
		.sys_clk       (sys_clk),
		.rstn          (rstn),
		.powerUpDone   (powerUpDone),
		.refreshDue    (refreshDue),
		.refreshIssued (refreshIssued),
		.hostRead      (hostRead),
		.hostWrite     (hostWrite),
		.hostWait      (hostWait),
		.bank          (bank),
		.row           (row),
		.col           (col),
		.reqWrite      (reqWrite),
		.accept        (accept),
		.driveData     (driveData),
		.csN           (csN),
		.rasN          (rasN),
		.casN          (casN),
		.weN           (weN),
		.ba            (ba),
		.addr          (addr)
	);

endmodule

`default_nettype wire

// File: bench/sdramModel.sv
`timescale 1ns/100ps
`default_nettype none

module sdramModel
	import sdramGeomPkg::*, sdramCmdPkg::*;
#(
	parameter int InitRefreshes = 8,
	parameter int MaxRefreshGap = 68
) (
	input  logic                      sys_clk,
	input  logic                      rstn, // Pins are not decoded while low
	input  logic                      csN,
	input  logic                      rasN,
	input  logic                      casN,
	input  logic                      weN,
	input  logic [BankWidth-1:0]      ba,
	input  logic [SdramAddrWidth-1:0] addr,
	input  logic [MaskWidth-1:0]      dqm,
	inout  wire  [DataWidth-1:0]      dq
);

	// Truth table codes, {csN, rasN, casN, weN}
	localparam logic [3:0] ModeCode = 4'b0000;
	localparam logic [3:0] RefCode  = 4'b0001;
	localparam logic [3:0] PreCode  = 4'b0010;
	localparam logic [3:0] ActCode  = 4'b0011;
	localparam logic [3:0] WrCode   = 4'b0100;
	localparam logic [3:0] RdCode   = 4'b0101;
	localparam logic [3:0] NopCode  = 4'b0111;

	// CL 2 in A6..A4, sequential, burst length 1
	localparam logic [SdramAddrWidth-1:0] ModeExpected = 12'h020;

	logic [DataWidth-1:0] mem [logic [AddrWidth-1:0]];
	logic [RowWidth-1:0]  openRow [4];
	logic [3:0]           rowOpen = '0;
	int                   initPhase = 0; // 0 before precharge, 1 init refreshes, 2 ready
	int                   initRefs = 0;
	int                   cycle = 0;
	int                   lastRefresh = 0;
	logic                 gapReported = 1'b0;
	logic                 initDone = 1'b0;
	int                   activeCount = 0;
	int                   refreshCount = 0;
	int                   violations = 0;
	logic [AddrWidth-1:0] lastAddr = '0;
	logic [AddrWidth-1:0] wordAddr;
	logic [DataWidth-1:0] word;
	logic [DataWidth-1:0] readWord = '0;
	logic [DataWidth-1:0] qOut = '0;
	logic                 readPending = 1'b0;
	logic                 driveQ = 1'b0;
	logic [3:0]           cmd;

	assign cmd = {csN, rasN, casN, weN};
	assign dq  = driveQ ? qOut : {DataWidth{1'bz}}; // Read word two edges after READ

	task automatic reportViolation(input string what);
		violations++;
		$display("Protocol violation at time %0t: %s", $time, what);
	endtask

	always @(posedge sys_clk) begin
		cycle = cycle + 1;
		driveQ      <= readPending;
		qOut        <= readWord;
		readPending <= 1'b0;
		if (rstn) begin
			if (cmd == RefCode) begin
				refreshCount++;
				lastRefresh = cycle;
				gapReported = 1'b0;
			end else if (refreshCount > 0 && !gapReported && cycle - lastRefresh > MaxRefreshGap) begin
				reportViolation("refresh interval too long");
				gapReported = 1'b1;
			end
			if (initPhase == 0) begin
				if (cmd == PreCode && addr[10])
					initPhase = 1;
				else if (cmd != NopCode)
					reportViolation("command other than precharge-all opens the init");
			end else if (initPhase == 1) begin
				if (cmd == RefCode) begin
					initRefs++;
				end else if (cmd == ModeCode) begin
					if (initRefs != InitRefreshes)
						reportViolation("mode set after the wrong number of init refreshes");
					if (addr != ModeExpected)
						reportViolation("mode register value is wrong");
					initPhase = 2;
					initDone  = 1'b1;
				end else if (cmd != NopCode) begin
					reportViolation("unexpected command during the init refreshes");
				end
			end else begin
				case (cmd)
					ActCode: begin
						openRow[ba] = addr[RowWidth-1:0];
						rowOpen[ba] = 1'b1;
						activeCount++;
					end
					WrCode, RdCode: begin
						if (!rowOpen[ba])
							reportViolation("access to a bank with no open row");
						if (!addr[10])
							reportViolation("access without auto precharge");
						wordAddr    = {ba, openRow[ba], addr[ColWidth-1:0]};
						lastAddr    = wordAddr;
						rowOpen[ba] = 1'b0; // Closed by auto precharge
						word        = mem.exists(wordAddr) ? mem[wordAddr] : '0;
						if (cmd == WrCode) begin
							for (int l = 0; l < MaskWidth; l++)
								if (!dqm[l]) word[l*8 +: 8] = dq[l*8 +: 8];
							mem[wordAddr] = word;
						end else begin
							readWord    <= word;
							readPending <= 1'b1;
						end
					end
					RefCode, NopCode: ;
					default: reportViolation("unexpected command after init");
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/sdramCtrlTb.sv
`timescale 1ns/100ps
`default_nettype none

module sdramCtrlTb
	import sdramGeomPkg::*, sdramCmdPkg::*;
();

	localparam int PowerUpCycles = 100;
	localparam int RefreshCycles = 60;
	localparam int InitRefreshes = 8;
	localparam int RandomPairs   = 16;
	localparam int Entries       = 6 + 2 * RandomPairs;
	localparam int TimeoutCycles = PowerUpCycles + 40 + Entries * 12;
	localparam int IdleStretch   = 130; // Two refresh periods and more
	localparam int OpWrite = 0;
	localparam int OpRead  = 1;
	localparam int OpIdle  = 2;
	localparam int OpBoth  = 3;

	logic                      sys_clk = 1'b0;
	logic                      rstn;
	logic [AddrWidth-1:0]      hostAddr;
	logic [MaskWidth-1:0]      hostByteEn;
	logic                      hostWrite;
	logic                      hostRead;
	logic [DataWidth-1:0]      hostWrData;
	logic [DataWidth-1:0]      hostRdData;
	logic                      hostWait;
	logic                      csN, rasN, casN, weN;
	logic [BankWidth-1:0]      ba;
	logic [SdramAddrWidth-1:0] addr;
	logic [MaskWidth-1:0]      dqm;
	wire  [DataWidth-1:0]      dq;

	int                   opTab   [Entries];
	logic [AddrWidth-1:0] addrTab [Entries];
	logic [MaskWidth-1:0] beTab   [Entries];
	logic [DataWidth-1:0] wrTab   [Entries];
	logic [DataWidth-1:0] expTab  [Entries];
	logic [DataWidth-1:0] shadow  [logic [AddrWidth-1:0]]; // Expected memory contents
	int                   entryCount = 0;
	int                   cycleCount = 0;
	int                   errors = 0;
	logic [31:0]          seed = 32'h2fa8_4915;

	always #4 sys_clk = ~sys_clk;

	sdramCtrlTop #(
		.PowerUpCycles (PowerUpCycles),
		.RefreshCycles (RefreshCycles),
		.InitRefreshes (InitRefreshes)
	) sdramCtrlTop_inst (.*);

	sdramModel #(
		.InitRefreshes (InitRefreshes),
		.MaxRefreshGap (RefreshCycles + 8)
	) sdramModel_inst (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Byte enable high means the lane takes the new data
	function automatic logic [DataWidth-1:0] mergeLanes(input logic [DataWidth-1:0] old,
			input logic [DataWidth-1:0] wr, input logic [MaskWidth-1:0] be);
		logic [DataWidth-1:0] word;
		word = old;
		if (be[0]) word[7:0] = wr[7:0];
		if (be[1]) word[15:8] = wr[15:8];
		return word;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic addEntry(input int op, input logic [AddrWidth-1:0] a,
			input logic [MaskWidth-1:0] be, input logic [DataWidth-1:0] d);
		logic [DataWidth-1:0] old;
		old = shadow.exists(a) ? shadow[a] : '0;
		opTab[entryCount]   = op;
		addrTab[entryCount] = a;
		beTab[entryCount]   = be;
		wrTab[entryCount]   = d;
		expTab[entryCount]  = old;
		if (op == OpWrite)
			shadow[a] = mergeLanes(old, d, be);
		entryCount++;
	endtask

	// Starts and ends on a falling edge
	task automatic runEntry(input int i);
		int actBefore;
		actBefore  = sdramModel_inst.activeCount;
		hostAddr   = addrTab[i];
		hostByteEn = beTab[i];
		hostWrData = wrTab[i];
		hostWrite  = (opTab[i] == OpWrite) || (opTab[i] == OpBoth);
		hostRead   = (opTab[i] == OpRead) || (opTab[i] == OpBoth);
		if (opTab[i] == OpIdle) begin
			repeat (IdleStretch) @(negedge sys_clk);
		end else if (opTab[i] == OpBoth) begin
			repeat (20) begin
				@(negedge sys_clk);
				compareValue("hostWait", 32'(hostWait), 32'd1);
			end
			compareValue("ACTIVATE count", sdramModel_inst.activeCount, actBefore);
		end else begin
			@(negedge sys_clk);
			while (hostWait) @(negedge sys_clk);
			if (opTab[i] == OpRead)
				compareValue("hostRdData", 32'(hostRdData), 32'(expTab[i]));
			compareValue("SDRAM word address", 32'(sdramModel_inst.lastAddr), 32'(addrTab[i]));
		end
		hostWrite = 1'b0;
		hostRead  = 1'b0;
	endtask

	// No host handshake before the mode register is set
	always @(negedge sys_clk) begin
		if (rstn && !sdramModel_inst.initDone)
			compareValue("hostWait before init", 32'(hostWait), 32'd1);
	end

	always @(posedge sys_clk) begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: stimulus not finished after %0d cycles", cycleCount);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		logic [AddrWidth-1:0] randAddr;
		rstn       = 1'b0;
		hostAddr   = '0;
		hostByteEn = '0;
		hostWrite  = 1'b0;
		hostRead   = 1'b0;
		hostWrData = '0;
		addEntry(OpWrite, 22'h000010, 2'b11, 16'ha5c3);
		addEntry(OpRead,  22'h000010, 2'b11, '0);
		addEntry(OpWrite, 22'h000010, 2'b01, 16'h1234); // Low lane only
		addEntry(OpRead,  22'h000010, 2'b11, '0);
		addEntry(OpBoth,  22'h2b1c40, 2'b11, 16'hffff);
		addEntry(OpIdle,  '0, '0, '0);
		for (int n = 0; n < RandomPairs; n++) begin
			seed     = xorshift(seed);
			randAddr = seed[AddrWidth-1:0];
			seed     = xorshift(seed);
			addEntry(OpWrite, randAddr, 2'b11, seed[DataWidth-1:0]);
		end
		for (int n = 0; n < RandomPairs; n++)
			addEntry(OpRead, addrTab[6 + n], 2'b11, '0);

		repeat (4) @(negedge sys_clk);
		rstn = 1'b1;
		for (int i = 0; i < entryCount; i++)
			runEntry(i);
		repeat (4) @(negedge sys_clk);

		if (sdramModel_inst.refreshCount <= InitRefreshes) begin
			errors++;
			$display("No periodic refresh was seen after initialisation");
		end
		$display("Summary: %0d value errors, %0d protocol violations, %0d refreshes",
			errors, sdramModel_inst.violations, sdramModel_inst.refreshCount);
		if (errors == 0 && sdramModel_inst.violations == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sdramCtrlTop.f
source/sdramGeomPkg.sv
source/sdramCmdPkg.sv
source/sdramRefreshSched.sv
source/sdramHostPort.sv
source/sdramCmdSeq.sv
source/sdramCtrlTop.sv
bench/sdramModel.sv
bench/sdramCtrlTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module sdramCtrlTb -f sdramCtrlTop.f

result=$(./obj_dir/VsdramCtrlTb)
echo "$result"

if echo "$result" | grep -qx "PASS: all tests"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
